//--- rtl/mips_pkg.sv
package mips_pkg;

    //////////////////////////////
    // architectural types
    //////////////////////////////

    typedef logic [31:0] word_t;  // one machine word.

    //////////////////////////////
    // fixed addresses
    //////////////////////////////

    // first fetch after reset or flush.
    localparam word_t reset_vector = 32'hbfc0_0000;

endpackage

//--- rtl/fetch_pkg.sv
package fetch_pkg;

    //////////////////////////////
    // commit-side redirect
    //////////////////////////////

    typedef struct packed {
        logic            exception_valid;  // trap taken at commit.
        logic            is_eret;          // return from exception.
        logic            branch;           // taken conditional branch.
        logic            jump;             // j or jal.
        logic            jr;               // register jump.
        mips_pkg::word_t pcexception;      // exception handler entry.
        mips_pkg::word_t epc;              // eret target.
        mips_pkg::word_t pcbranch;         // branch target.
        mips_pkg::word_t pcjump;           // jump target.
        mips_pkg::word_t pcjr;             // jr target.
        mips_pkg::word_t branch_pc;        // address of the committed branch.
    } pc_data_t;

    //////////////////////////////
    // predictor result
    //////////////////////////////

    typedef struct packed {
        logic            taken;
        mips_pkg::word_t destpc;
    } bpb_result_t;

    //////////////////////////////
    // one decode slot
    //////////////////////////////

    typedef struct packed {
        mips_pkg::word_t instr_;           // raw instruction word.
        mips_pkg::word_t pcplus4;          // successor pc of this slot.
        logic            en;               // slot holds a valid word.
        logic            exception_instr;  // misaligned fetch address.
        logic            pred;             // predicted taken by the btb.
    } fetch_data_t;

endpackage

//--- rtl/redirect_select.sv
`timescale 1ns/1ps

module redirect_select (
    input  fetch_pkg::pc_data_t redirect,
    input  mips_pkg::word_t     seq_pc,
    output mips_pkg::word_t     pc_new,
    output logic                pc_upd
);

    // any commit-side redirect overrides fetch's own guess.
    assign pc_upd = redirect.exception_valid
                  | redirect.is_eret
                  | redirect.branch
                  | redirect.jump
                  | redirect.jr;

    //////////////////////////////
    // target by fixed priority
    //////////////////////////////

    always_comb
    begin
        if (redirect.exception_valid)
        begin
            pc_new = redirect.pcexception;
        end
        else if (redirect.is_eret)
        begin
            pc_new = redirect.epc;
        end
        else if (redirect.branch)
        begin
            pc_new = redirect.pcbranch;
        end
        else if (redirect.jump)
        begin
            pc_new = redirect.pcjump;
        end
        else if (redirect.jr)
        begin
            pc_new = redirect.pcjr;
        end
        else
        begin
            pc_new = seq_pc;  // sequential or predicted.
        end
    end

endmodule

//--- rtl/branch_target_buffer.sv
`timescale 1ns/1ps

module branch_target_buffer #(
    parameter int btb_entries = 16
) (
    input  logic                           clk,
    input  logic                           reset,
    input  mips_pkg::word_t                lookup_pc,
    input  fetch_pkg::pc_data_t            redirect,
    output fetch_pkg::bpb_result_t [1:0]   destpc_predict
);
    import mips_pkg::*;

    localparam int idx_w = (btb_entries > 1) ? $clog2(btb_entries) : 1;
    localparam logic [idx_w-1:0] idx_mask = idx_w'(btb_entries - 1);

    logic [btb_entries-1:0] valid;
    word_t                  tag    [btb_entries];
    word_t                  target [btb_entries];

    word_t            lookup_pc4;
    logic [idx_w-1:0] rd_idx1;
    logic [idx_w-1:0] rd_idx0;
    logic [idx_w-1:0] wr_idx;

    // word index, wrapped to the table size.
    function automatic logic [idx_w-1:0] idx_of(input word_t a);
        return a[2 +: idx_w] & idx_mask;
    endfunction

    assign lookup_pc4 = lookup_pc + 32'd4;
    assign rd_idx1    = idx_of(lookup_pc);
    assign rd_idx0    = idx_of(lookup_pc4);
    assign wr_idx     = idx_of(redirect.branch_pc);

    //////////////////////////////
    // training
    //////////////////////////////

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < btb_entries; i++)
            begin
                valid[i]  <= 1'b0;
                tag[i]    <= '0;
                target[i] <= '0;
            end
        end
        else if (redirect.branch)
        begin
            valid[wr_idx]  <= 1'b1;                // taken branch seen at commit.
            tag[wr_idx]    <= redirect.branch_pc;
            target[wr_idx] <= redirect.pcbranch;
        end
    end

    //////////////////////////////
    // lookup for both slots
    //////////////////////////////

    always_comb
    begin
        // slot 1 is the word at pc.
        destpc_predict[1].taken  = valid[rd_idx1] && (tag[rd_idx1] == lookup_pc);
        destpc_predict[1].destpc = target[rd_idx1];
        // slot 0 is the word at pc+4.
        destpc_predict[0].taken  = valid[rd_idx0] && (tag[rd_idx0] == lookup_pc4);
        destpc_predict[0].destpc = target[rd_idx0];
    end

endmodule

//--- rtl/fetch.sv
`timescale 1ns/1ps

module fetch (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flushF,
    input  logic                          stallF,
    input  logic                          addrOK,
    input  logic                          dataOK,
    input  logic                          hit,
    input  mips_pkg::word_t [1:0]         data,
    input  fetch_pkg::bpb_result_t [1:0]  destpc_predict,
    input  mips_pkg::word_t               pc_new,
    input  logic                          pc_upd,
    output mips_pkg::word_t               pc,
    output mips_pkg::word_t               seq_pc,
    output fetch_pkg::fetch_data_t [1:0]  fetch_data,
    output logic                          finishF
);
    import mips_pkg::*;
    import fetch_pkg::*;

    word_t       pcplus4;
    word_t       pcplus8;
    logic        pc_load;
    logic        redirected;
    logic        addr_accepted;
    logic        conflict;
    logic        misaligned;
    logic        slot1_consumed;
    bpb_result_t last_predict;
    bpb_result_t last_predict_next;

    assign pcplus4        = pc + 32'd4;
    assign pcplus8        = pc + 32'd8;
    assign misaligned     = (pcplus4[1:0] != 2'b00);
    assign slot1_consumed = destpc_predict[1].taken & hit;
    assign pc_load        = pc_upd | (~stallF & ~conflict);
    assign redirected     = pc_upd | flushF;      // both abandon the request in flight.

    //////////////////////////////
    // pc register
    //////////////////////////////

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            pc           <= reset_vector;
            last_predict <= '0;
        end
        else if (flushF)
        begin
            pc           <= reset_vector;
            last_predict <= '0;
        end
        else if (pc_load)
        begin
            pc           <= pc_new;
            last_predict <= pc_upd ? '0 : last_predict_next;
        end
    end

    //////////////////////////////
    // request tracking
    //////////////////////////////

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            addr_accepted <= 1'b0;
            conflict      <= 1'b0;
        end
        else if (dataOK)
        begin
            addr_accepted <= 1'b0;                 // request done.
            conflict      <= 1'b0;
        end
        else
        begin
            if (addrOK)
                addr_accepted <= 1'b1;
            if (redirected && (addr_accepted || addrOK))
                conflict <= 1'b1;                  // drop the data still to come.
        end
    end

    //////////////////////////////
    // next sequential pc
    //////////////////////////////

    always_comb
    begin
        if (slot1_consumed)
            seq_pc = destpc_predict[1].destpc;
        else if (last_predict.taken)
            seq_pc = last_predict.destpc;
        else if (hit)
            seq_pc = pcplus8;
        else
            seq_pc = pcplus4;
    end

    // prediction whose delay slot is not fetched yet.
    always_comb
    begin
        if (~hit & destpc_predict[1].taken)
            last_predict_next = destpc_predict[1];
        else if (hit & ~slot1_consumed & ~last_predict.taken & destpc_predict[0].taken)
            last_predict_next = destpc_predict[0];
        else
            last_predict_next = '0;
    end

    //////////////////////////////
    // slots for decode
    //////////////////////////////

    always_comb
    begin
        fetch_data[1].instr_          = data[0];
        fetch_data[1].pcplus4         = pcplus4;
        fetch_data[1].en              = 1'b1;
        fetch_data[1].exception_instr = misaligned;
        fetch_data[1].pred            = destpc_predict[1].taken;

        fetch_data[0].instr_          = data[1];
        fetch_data[0].pcplus4         = pcplus8;
        fetch_data[0].en              = hit & ~last_predict.taken;  // wrong path after a taken one.
        fetch_data[0].exception_instr = misaligned;
        fetch_data[0].pred            = destpc_predict[0].taken;
    end

    assign finishF = dataOK & ~conflict;

endmodule

//--- rtl/fetch_packet.sv
`timescale 1ns/1ps

module fetch_packet (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flushF,
    input  logic                          finishF,
    input  mips_pkg::word_t               pc,
    input  fetch_pkg::fetch_data_t [1:0]  fetch_data,
    output logic                          packet_valid,
    output mips_pkg::word_t [1:0]         pc_predict,
    output mips_pkg::word_t [1:0]         instr_predict,
    output fetch_pkg::fetch_data_t [1:0]  fetch_data_out
);

    //////////////////////////////
    // valid flag
    //////////////////////////////

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            packet_valid <= 1'b0;
        else
            packet_valid <= finishF & ~flushF;  // one cycle per returned fetch.
    end

    //////////////////////////////
    // payload
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (finishF)
        begin
            pc_predict     <= {pc, pc + 32'd4};
            instr_predict  <= {fetch_data[1].instr_, fetch_data[0].instr_};
            fetch_data_out <= fetch_data;
        end
    end

endmodule

//--- rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter int btb_entries = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flushF,
    input  logic                          stallF,
    input  fetch_pkg::pc_data_t           redirect,
    input  logic                          addrOK,
    input  logic                          dataOK,
    input  logic                          hit,
    input  mips_pkg::word_t [1:0]         data,
    output mips_pkg::word_t               addr,
    output logic                          packet_valid,
    output mips_pkg::word_t [1:0]         pc_predict,
    output mips_pkg::word_t [1:0]         instr_predict,
    output fetch_pkg::fetch_data_t [1:0]  fetch_data_out
);
    import mips_pkg::*;
    import fetch_pkg::*;

    word_t             pc_new;
    word_t             seq_pc;
    logic              pc_upd;
    logic              finishF;
    bpb_result_t [1:0] destpc_predict;
    fetch_data_t [1:0] fetch_data;

    redirect_select u_redirect_select (
        .redirect (redirect),
        .seq_pc   (seq_pc),
        .pc_new   (pc_new),
        .pc_upd   (pc_upd)
    );

    branch_target_buffer #(
        .btb_entries (btb_entries)
    ) u_btb (
        .clk            (clk),
        .reset          (reset),
        .lookup_pc      (addr),
        .redirect       (redirect),
        .destpc_predict (destpc_predict)
    );

    // addr is the pc register itself.
    fetch u_fetch (
        .clk            (clk),
        .reset          (reset),
        .flushF         (flushF),
        .stallF         (stallF),
        .addrOK         (addrOK),
        .dataOK         (dataOK),
        .hit            (hit),
        .data           (data),
        .destpc_predict (destpc_predict),
        .pc_new         (pc_new),
        .pc_upd         (pc_upd),
        .pc             (addr),
        .seq_pc         (seq_pc),
        .fetch_data     (fetch_data),
        .finishF        (finishF)
    );

    fetch_packet u_fetch_packet (
        .clk            (clk),
        .reset          (reset),
        .flushF         (flushF),
        .finishF        (finishF),
        .pc             (addr),
        .fetch_data     (fetch_data),
        .packet_valid   (packet_valid),
        .pc_predict     (pc_predict),
        .instr_predict  (instr_predict),
        .fetch_data_out (fetch_data_out)
    );

endmodule

//--- tests/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker (
    input logic            clk,
    input logic            reset,
    input logic            stallF,
    input logic            flushF,
    input logic            pc_upd,
    input logic            dataOK,
    input logic            packet_valid,
    input mips_pkg::word_t addr
);

    //////////////////////////////
    // fetch address
    //////////////////////////////

    // redirect and flush still move pc under a stall.
    stall_holds_addr: assert property (
        @(posedge clk) disable iff (reset)
        (stallF && !pc_upd && !flushF) |=> $stable(addr)
    ) else $error("addr changed across a stalled cycle");

    //////////////////////////////
    // packet valid
    //////////////////////////////

    quiet_after_reset: assert property (
        @(posedge clk) reset |=> !packet_valid
    ) else $error("packet_valid high right after reset");

    valid_needs_data: assert property (
        @(posedge clk) disable iff (reset)
        $rose(packet_valid) |-> $past(dataOK)
    ) else $error("packet_valid rose without a dataOK before it");

endmodule

bind fetch_top fetch_checker u_checker (
    .clk          (clk),
    .reset        (reset),
    .stallF       (stallF),
    .flushF       (flushF),
    .pc_upd       (pc_upd),
    .dataOK       (dataOK),
    .packet_valid (packet_valid),
    .addr         (addr)
);

//--- tests/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
    import mips_pkg::*;
    import fetch_pkg::*;

    localparam int pkt_timeout = 4;  // cycles to wait for packet_valid.

    typedef struct packed {
        logic [4:0] kinds;     // exception, eret, branch, jump, jr.
        word_t      target;
        word_t      bpc;
        logic       hit;
        logic       stall;
        logic       flush;
        logic       carry;     // held prediction active in this fetch.
        logic [1:0] pred;      // btb hit expected in slot 1 and slot 0.
        word_t      exp_addr;
    } row_t;

    logic              clk;
    logic              reset;
    logic              flushF;
    logic              stallF;
    pc_data_t          redirect;
    logic              addrOK;
    logic              dataOK;
    logic              hit;
    word_t [1:0]       data;
    word_t             addr;
    logic              packet_valid;
    word_t [1:0]       pc_predict;
    word_t [1:0]       instr_predict;
    fetch_data_t [1:0] fetch_data_out;
    row_t              rows[$];
    int                checks = 0;
    int                errors = 0;

    fetch_top #(.btb_entries(16)) dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word_t mem_word(input word_t a);
        return a ^ 32'ha5a5_a5a5;
    endfunction

    // each kind gets its own target so the winner is visible.
    function automatic pc_data_t make_redirect(input logic [4:0] kinds, input word_t t,
                                               input word_t bpc);
        pc_data_t rd;
        rd = '0;
        {rd.exception_valid, rd.is_eret, rd.branch, rd.jump, rd.jr} = kinds;
        rd.pcexception = t;
        rd.epc         = t + 32'h10;
        rd.pcbranch    = t + 32'h20;
        rd.pcjump      = t + 32'h30;
        rd.pcjr        = t + 32'h40;
        rd.branch_pc   = bpc;
        return rd;
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got == exp)
        else
        begin
            errors++;
            $display("mismatch %s got %h expected %h", name, got, exp);
        end
    endtask

    //////////////////////////////
    // one fetch through the memory model
    //////////////////////////////

    task automatic apply_row(input row_t r);
        word_t a;
        word_t a4;
        int    wait_a;
        int    wait_d;
        logic  seen;
        logic  exp_valid;
        logic  exp_exc;
        a         = addr;
        a4        = a + 32'd4;
        exp_valid = (r.kinds == 5'b00000) && !r.flush;
        exp_exc   = (a[1:0] != 2'b00);
        wait_a    = $urandom_range(2, 0);
        wait_d    = $urandom_range(3, 1);
        for (int i = 0; i <= wait_a; i++)
            @(posedge clk);
        addrOK   <= 1'b1;
        redirect <= make_redirect(r.kinds, r.target, r.bpc);  // lands while in flight.
        for (int i = 0; i < wait_d; i++)
        begin
            @(posedge clk);
            addrOK   <= 1'b0;
            redirect <= '0;
        end
        dataOK <= 1'b1;
        hit    <= r.hit;
        data   <= {mem_word(a4), mem_word(a)};
        stallF <= r.stall;
        flushF <= r.flush;
        @(posedge clk);
        dataOK <= 1'b0;
        hit    <= 1'b0;
        stallF <= 1'b1;
        flushF <= 1'b0;
        seen = 1'b0;
        for (int i = 0; i < pkt_timeout && !seen; i++)
        begin
            @(negedge clk);
            seen = packet_valid;
        end
        checks++;
        assert (seen == exp_valid)
        else
        begin
            errors++;
            if (exp_valid)
                $display("no packet_valid after the fetch of %h", a);
            else
                $display("packet_valid rose for the dropped fetch of %h", a);
        end
        if (seen && exp_valid)
        begin
            check_value("pc_predict[1]", pc_predict[1], a);
            check_value("pc_predict[0]", pc_predict[0], a4);
            check_value("instr_predict[1]", instr_predict[1], mem_word(a));
            check_value("instr_predict[0]", instr_predict[0], mem_word(a4));
            check_value("slot1.instr_", fetch_data_out[1].instr_, mem_word(a));
            check_value("slot0.instr_", fetch_data_out[0].instr_, mem_word(a4));
            check_value("slot1.pcplus4", fetch_data_out[1].pcplus4, a + 32'd4);
            check_value("slot0.pcplus4", fetch_data_out[0].pcplus4, a + 32'd8);
            check_value("slot1.en", 32'(fetch_data_out[1].en), 32'd1);
            check_value("slot0.en", 32'(fetch_data_out[0].en), 32'(r.hit & ~r.carry));
            check_value("slot1.exception_instr", 32'(fetch_data_out[1].exception_instr),
                        32'(exp_exc));
            check_value("slot0.exception_instr", 32'(fetch_data_out[0].exception_instr),
                        32'(exp_exc));
            check_value("slot1.pred", 32'(fetch_data_out[1].pred), 32'(r.pred[1]));
            check_value("slot0.pred", 32'(fetch_data_out[0].pred), 32'(r.pred[0]));
        end
        check_value("addr", addr, r.exp_addr);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial
    begin
        void'($urandom(32'h7f7a75c6));
        reset    <= 1'b1;
        flushF   <= 1'b0;
        stallF   <= 1'b1;  // held except in data cycles.
        redirect <= '0;
        addrOK   <= 1'b0;
        dataOK   <= 1'b0;
        hit      <= 1'b0;
        data     <= '0;
        // kinds, target, bpc, hit, stall, flush, carry, pred, expected next addr
        rows.push_back('{5'b00000, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0, 2'b00, 32'hbfc0_0008});
        rows.push_back('{5'b00000, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0, 2'b00, 32'hbfc0_000c});
        rows.push_back('{5'b00000, 32'h0, 32'h0, 1'b1, 1'b1, 1'b0, 1'b0, 2'b00, 32'hbfc0_000c});
        rows.push_back('{5'b00000, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0, 2'b00, 32'hbfc0_0014});
        rows.push_back('{5'b11111, 32'h8000_0100, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0, 2'b00,
                         32'h8000_0100});
        rows.push_back('{5'b01011, 32'h8000_0200, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0, 2'b00,
                         32'h8000_0210});
        rows.push_back('{5'b00101, 32'h8000_0300, 32'h8000_0400, 1'b0, 1'b0, 1'b0, 1'b0, 2'b00,
                         32'h8000_0320});
        rows.push_back('{5'b00011, 32'h8000_03d0, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0, 2'b00,
                         32'h8000_0400});
        rows.push_back('{5'b00000, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0, 2'b10, 32'h8000_0320});
        rows.push_back('{5'b00000, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0, 2'b00, 32'h8000_0324});
        rows.push_back('{5'b00010, 32'h8000_03cc, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0, 2'b00,
                         32'h8000_03fc});
        rows.push_back('{5'b00000, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0, 2'b01, 32'h8000_0404});
        rows.push_back('{5'b00000, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0, 1'b1, 2'b00, 32'h8000_0320});
        rows.push_back('{5'b00001, 32'h8000_0502, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0, 2'b00,
                         32'h8000_0542});
        rows.push_back('{5'b00000, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0, 2'b00, 32'h8000_054a});
        rows.push_back('{5'b00000, 32'h0, 32'h0, 1'b1, 1'b0, 1'b1, 1'b0, 2'b00, 32'hbfc0_0000});
        rows.push_back('{5'b00000, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0, 2'b00, 32'hbfc0_0004});
        for (int i = 0; i < 10; i++)
            @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("addr", addr, 32'hbfc0_0000);
        check_value("packet_valid", 32'(packet_valid), 32'd0);
        foreach (rows[i])
            apply_row(rows[i]);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- build.f
rtl/mips_pkg.sv
rtl/fetch_pkg.sv
rtl/redirect_select.sv
rtl/branch_target_buffer.sv
rtl/fetch.sv
rtl/fetch_packet.sv
rtl/fetch_top.sv
tests/fetch_checker.sv
tests/fetch_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module fetch_tb -f build.f -o fetch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/fetch_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
    exit 0
fi
exit 1
